/* build.f */
source/minimig_map_pkg.sv
source/minimig_bus_pkg.sv
source/cpu_bus_bridge.sv
source/bitplane_dma.sv
source/chip_bus_arbiter.sv
source/memory_decoder.sv
source/sram_bridge.sv
source/minimig_core.sv
test/sram_model.sv
test/tb_minimig_core.sv

/* run.sh */
#!/bin/sh
# build and run the chip bus testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ns -Wno-fatal \
	--top-module tb_minimig_core -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_minimig_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

/* test/tb_minimig_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_minimig_core;

	localparam int WAIT_LIMIT  = 4000; // cycles per wait loop
	localparam int NUM_RANDOM  = 16;   // random chip/slow word pairs
	localparam int DMA_RUNS    = 4;
	localparam int DMA_MAX_LEN = 24;

	// segment values of addr[22:18]
	localparam logic [4:0] CHIP_SEG = 5'h00; // 0x000000
	localparam logic [4:0] SLOW_SEG = 5'h18; // 0xc00000
	localparam logic [4:0] KICK_SEG = 5'h1f; // 0xf80000
	localparam logic [4:0] VOID_SEG = 5'h08; // 0x400000, nothing there

	logic        clk = 1'b0;
	logic        reset;
	logic        ovl_i;
	logic [22:0] cpu_addr_i;
	logic [15:0] cpu_wdata_i;
	logic        _cpu_as_i, _cpu_uds_i, _cpu_lds_i, cpu_r_w_i;
	logic [15:0] cpu_data_o;
	logic        _cpu_dtack_o;
	logic        dma_start_i;
	logic [17:0] dma_ptr_i;
	logic [7:0]  dma_len_i;
	logic [15:0] dma_data_o;
	logic        dma_valid_o, dma_busy_o;
	logic [19:0] ram_addr_o;
	logic [15:0] ram_data_o, ram_data_i;
	logic        _ram_we_o, _ram_oe_o, _ram_bhe_o, _ram_ble_o;

	integer      seed = 32'h6c93;
	logic [15:0] shadow [int unsigned]; // sram words written so far
	logic [16:0] cpu_exp_q [$];         // {check, expected read word}
	logic [15:0] dma_exp_q [$];
	logic        dtack_prev;

	always #10 clk = ~clk;

	minimig_core minimig_core_inst (.*);

	sram_model sram_inst (
		.addr_i(ram_addr_o), .data_i(ram_data_o), .data_o(ram_data_i),
		._we_i(_ram_we_o), ._oe_i(_ram_oe_o), ._bhe_i(_ram_bhe_o), ._ble_i(_ram_ble_o));

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp)
		else stop_on_error($sformatf("ERROR at %0t ns: %s = %h, expected %h",
			$time, name, got, exp));
	endtask

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [15:0] fill_word(input logic [19:0] a);
		return a[15:0] ^ {4{a[19:16]}} ^ 16'ha5c3; // same pattern the sram starts with
	endfunction

	//------------------------------------------------------------
	// reference map: chip, slow, kick, overlay, rom protect
	//------------------------------------------------------------
	function automatic logic [15:0] predict_access(input logic [22:0] addr, input logic we,
			input logic [1:0] be, input logic [15:0] wdata, input logic ovl);
		logic [1:0]  bank;
		logic        mapped;
		logic        wr;
		logic [19:0] sa;
		logic [15:0] word;
		bank   = 2'd0;
		mapped = 1'b1;
		wr     = we;
		case (addr[22:18])
			CHIP_SEG: bank = (ovl && !we) ? 2'd2 : 2'd0; // rom shows through on reads
			SLOW_SEG: bank = 2'd1;
			KICK_SEG: begin
				bank = 2'd2;
				wr   = 1'b0; // rom keeps its contents
			end
			default: mapped = 1'b0;
		endcase
		sa   = {bank, addr[17:0]};
		word = shadow.exists(sa) ? shadow[sa] : fill_word(sa);
		if (mapped && wr) begin
			if (be[1])
				word[15:8] = wdata[15:8];
			if (be[0])
				word[7:0] = wdata[7:0];
			shadow[sa] = word;
		end
		return (mapped && !we) ? word : 16'h0000; // unmapped reads as zero
	endfunction

	// one 68000 bus cycle, called on a falling edge
	task automatic cpu_access(input logic [22:0] addr, input logic we, input logic [1:0] be,
			input logic [15:0] wdata, input logic check);
		logic [15:0] expect_word;
		int          n;
		expect_word = predict_access(addr, we, be, wdata, ovl_i);
		cpu_exp_q.push_back({check, expect_word});
		cpu_addr_i  = addr;
		cpu_wdata_i = wdata;
		cpu_r_w_i   = !we;
		_cpu_uds_i  = !be[1];
		_cpu_lds_i  = !be[0];
		_cpu_as_i   = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				stop_on_error("timeout: CPU access never got dtack");
		end while (_cpu_dtack_o);
		_cpu_as_i  = 1'b1; // release the cycle
		_cpu_uds_i = 1'b1;
		_cpu_lds_i = 1'b1;
		cpu_r_w_i  = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				stop_on_error("timeout: dtack stayed low after address strobe release");
		end while (!_cpu_dtack_o);
	endtask

	// bitplane run, optional second start while busy
	task automatic dma_run(input logic [17:0] ptr, input logic [7:0] len, input logic restart);
		int          n;
		logic [17:0] p;
		for (int i = 0; i < int'(len); i++) begin
			p = ptr + 18'(i); // wraps inside chip bank
			dma_exp_q.push_back(predict_access({CHIP_SEG, p}, 1'b0, 2'b11, 16'h0000, 1'b0));
		end
		dma_ptr_i   = ptr;
		dma_len_i   = len;
		dma_start_i = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				stop_on_error("timeout: DMA run never finished");
			dma_start_i = restart && (n == 3); // must be ignored
			dma_len_i   = (n == 3) ? len + 8'd7 : len;
			dma_ptr_i   = (n == 3) ? ~ptr : ptr;
		end while (dma_busy_o);
		dma_start_i = 1'b0;
		assert (dma_exp_q.size() == 0)
		else stop_on_error("DMA run ended before all requested words were delivered");
	endtask

	//------------------------------------------------------------
	// compare every cpu read and every dma word
	//------------------------------------------------------------
	always @(negedge clk) begin : compare_responses
		logic [16:0] entry;
		if (reset) begin
			dtack_prev = 1'b1;
		end else begin
			if (!_cpu_dtack_o && dtack_prev) begin
				assert (cpu_exp_q.size() != 0)
				else stop_on_error("dtack arrived with no CPU access outstanding");
				entry = cpu_exp_q.pop_front();
				if (entry[16])
					check_value("cpu_data_o", cpu_data_o, entry[15:0]);
			end
			dtack_prev = _cpu_dtack_o;
			if (dma_valid_o) begin
				assert (dma_exp_q.size() != 0)
				else stop_on_error("DMA delivered more words than requested");
				check_value("dma_data_o", dma_data_o, dma_exp_q.pop_front());
			end
		end
	end

	initial begin : stimulus
		logic [17:0] offs [NUM_RANDOM];
		logic [15:0] data [NUM_RANDOM];
		logic [31:0] r;
		logic [17:0] off;
		logic [4:0]  seg;
		logic [7:0]  len;
		reset       = 1'b1;
		ovl_i       = 1'b0;
		cpu_addr_i  = '0;
		cpu_wdata_i = '0;
		_cpu_as_i   = 1'b1;
		_cpu_uds_i  = 1'b1;
		_cpu_lds_i  = 1'b1;
		cpu_r_w_i   = 1'b1;
		dma_start_i = 1'b0;
		dma_ptr_i   = '0;
		dma_len_i   = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// idle outputs straight out of reset
		check_value("_cpu_dtack_o", 16'(_cpu_dtack_o), 16'd1);
		check_value("dma_valid_o", 16'(dma_valid_o), 16'd0);
		check_value("dma_busy_o", 16'(dma_busy_o), 16'd0);
		check_value("_ram_we_o", 16'(_ram_we_o), 16'd1);
		check_value("_ram_oe_o", 16'(_ram_oe_o), 16'd1);
		check_value("_ram_bhe_o", 16'(_ram_bhe_o), 16'd1);
		check_value("_ram_ble_o", 16'(_ram_ble_o), 16'd1);

		// chip and slow at the same offset, different data
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r       = next_rand();
			offs[i] = r[17:0];
			r       = next_rand();
			data[i] = r[15:0];
			cpu_access({CHIP_SEG, offs[i]}, 1'b1, 2'b11, data[i], 1'b0);
			cpu_access({SLOW_SEG, offs[i]}, 1'b1, 2'b11, ~data[i], 1'b0);
		end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			cpu_access({CHIP_SEG, offs[i]}, 1'b0, 2'b11, 16'h0000, 1'b1);
			cpu_access({SLOW_SEG, offs[i]}, 1'b0, 2'b11, 16'h0000, 1'b1);
		end

		// single byte lanes
		for (int s = 0; s < 2; s++) begin
			seg = (s == 0) ? CHIP_SEG : SLOW_SEG;
			off = offs[s];
			cpu_access({seg, off}, 1'b1, 2'b11, 16'h1234, 1'b0);
			cpu_access({seg, off}, 1'b1, 2'b10, 16'hab00, 1'b0); // upper only
			cpu_access({seg, off}, 1'b0, 2'b11, 16'h0000, 1'b1);
			cpu_access({seg, off}, 1'b1, 2'b01, 16'h00cd, 1'b0); // lower only
			cpu_access({seg, off}, 1'b0, 2'b11, 16'h0000, 1'b1);
		end

		// rom protect, unmapped space, overlay
		off = offs[2];
		cpu_access({KICK_SEG, off}, 1'b1, 2'b11, 16'hdead, 1'b0);
		cpu_access({KICK_SEG, off}, 1'b0, 2'b11, 16'h0000, 1'b1);
		cpu_access({VOID_SEG, off}, 1'b1, 2'b11, 16'hbeef, 1'b0);
		cpu_access({VOID_SEG, off}, 1'b0, 2'b11, 16'h0000, 1'b1);
		ovl_i = 1'b1;
		cpu_access({CHIP_SEG, off}, 1'b0, 2'b11, 16'h0000, 1'b1); // rom data
		cpu_access({CHIP_SEG, off}, 1'b1, 2'b11, 16'hc0de, 1'b0); // lands in chip
		cpu_access({CHIP_SEG, off}, 1'b0, 2'b11, 16'h0000, 1'b1);
		ovl_i = 1'b0;
		cpu_access({CHIP_SEG, off}, 1'b0, 2'b11, 16'h0000, 1'b1);

		//------------------------------------------------------------
		// dma runs with cpu traffic alongside
		//------------------------------------------------------------
		for (int run = 0; run < DMA_RUNS; run++) begin
			r   = next_rand();
			off = r[17:0];
			len = 8'(1 + r[31:24] % DMA_MAX_LEN);
			fork
				dma_run(off, len, run == 1);
				begin : cpu_side
					for (int k = 0; k < 3; k++) begin
						r = next_rand();
						cpu_access({SLOW_SEG, r[17:0]}, 1'b1, 2'b11, r[31:16], 1'b0);
						cpu_access({SLOW_SEG, r[17:0]}, 1'b0, 2'b11, 16'h0000, 1'b1);
						cpu_access({CHIP_SEG, r[17:0] ^ 18'h2aaaa}, 1'b0, 2'b11, 16'h0000, 1'b1);
					end
				end
			join
		end

		repeat (4) @(negedge clk);
		if (cpu_exp_q.size() == 0 && dma_exp_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_on_error("responses still outstanding at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* test/sram_model.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_model (
	input  wire [19:0]  addr_i,   // {bank, word offset}
	input  wire [15:0]  data_i,
	output logic [15:0] data_o,
	input  wire         _we_i,
	input  wire         _oe_i,
	input  wire         _bhe_i,   // upper byte lane
	input  wire         _ble_i    // lower byte lane
);
	logic [15:0] mem [0:(1 << 20) - 1];

	// power-up contents, rom bank included, every address bit counts
	function automatic logic [15:0] fill_word(input logic [19:0] a);
		return a[15:0] ^ {4{a[19:16]}} ^ 16'ha5c3;
	endfunction

	initial begin
		for (int i = 0; i < (1 << 20); i++)
			mem[i] = fill_word(20'(i));
	end

	// asynchronous write, each lane follows its own enable
	always @* begin
		if (!_we_i && !_bhe_i)
			mem[addr_i][15:8] = data_i[15:8];
		if (!_we_i && !_ble_i)
			mem[addr_i][7:0] = data_i[7:0];
	end

	assign data_o = !_oe_i ? mem[addr_i] : 16'h0000; // undriven bus reads low

endmodule

`default_nettype wire

/* source/minimig_core.sv */
`timescale 1ns/1ns
`default_nettype none

module minimig_core (
	input  wire                                        clk,
	input  wire                                        reset,
	input  wire                                        ovl_i,
	// 68000 side
	input  wire [22:0]                                 cpu_addr_i,
	input  wire [15:0]                                 cpu_wdata_i,
	input  wire                                        _cpu_as_i,
	input  wire                                        _cpu_uds_i,
	input  wire                                        _cpu_lds_i,
	input  wire                                        cpu_r_w_i,
	output logic [15:0]                                cpu_data_o,
	output logic                                       _cpu_dtack_o,
	// bitplane fetch
	input  wire                                        dma_start_i,
	input  wire [minimig_map_pkg::BANK_WORD_BITS-1:0]  dma_ptr_i,
	input  wire [7:0]                                  dma_len_i,
	output logic [15:0]                                dma_data_o,
	output logic                                       dma_valid_o,
	output logic                                       dma_busy_o,
	// sram pins
	output logic [minimig_map_pkg::SRAM_ADDR_BITS-1:0] ram_addr_o,
	output logic [15:0]                                ram_data_o,
	input  wire [15:0]                                 ram_data_i,
	output logic                                       _ram_we_o,
	output logic                                       _ram_oe_o,
	output logic                                       _ram_bhe_o,
	output logic                                       _ram_ble_o
);
	import minimig_bus_pkg::*;

	bus_req_t cpu_req, dma_req, gnt_req; // masters and granted request
	bus_rsp_t cpu_rsp, dma_rsp, mem_rsp;
	mem_cmd_t mem_cmd;

	cpu_bus_bridge cpu_bridge_inst (
		.clk, .reset, .cpu_addr_i, .cpu_wdata_i, ._cpu_as_i, ._cpu_uds_i,
		._cpu_lds_i, .cpu_r_w_i, .cpu_data_o, ._cpu_dtack_o,
		.req_o(cpu_req), .rsp_i(cpu_rsp));

	bitplane_dma dma_inst (
		.clk, .reset, .dma_start_i, .dma_ptr_i, .dma_len_i, .dma_data_o,
		.dma_valid_o, .dma_busy_o, .req_o(dma_req), .rsp_i(dma_rsp));

	chip_bus_arbiter arbiter_inst (
		.clk, .reset, .cpu_req_i(cpu_req), .dma_req_i(dma_req),
		.cpu_rsp_o(cpu_rsp), .dma_rsp_o(dma_rsp),
		.gnt_req_o(gnt_req), .mem_rsp_i(mem_rsp));

	memory_decoder decoder_inst (
		.clk, .reset, .ovl_i, .gnt_req_i(gnt_req), .mem_cmd_o(mem_cmd));

	sram_bridge sram_inst (
		.clk, .reset, .mem_cmd_i(mem_cmd), .mem_rsp_o(mem_rsp),
		.ram_addr_o, .ram_data_o, .ram_data_i,
		._ram_we_o, ._ram_oe_o, ._ram_bhe_o, ._ram_ble_o);

endmodule

`default_nettype wire

/* source/sram_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_bridge (
	input  wire                                        clk,
	input  wire                                        reset,
	input  wire minimig_bus_pkg::mem_cmd_t             mem_cmd_i,
	output minimig_bus_pkg::bus_rsp_t                  mem_rsp_o,
	output logic [minimig_map_pkg::SRAM_ADDR_BITS-1:0] ram_addr_o,
	output logic [15:0]                                ram_data_o,
	input  wire [15:0]                                 ram_data_i,
	output logic                                       _ram_we_o,
	output logic                                       _ram_oe_o,
	output logic                                       _ram_bhe_o,
	output logic                                       _ram_ble_o
);
	import minimig_bus_pkg::*;
	import minimig_map_pkg::*;

	mem_cmd_t                 cmd_q;   // held for the whole pin cycle
	logic                     busy_q;
	logic [SRAM_CNT_BITS-1:0] cnt_q;   // phase within the cycle
	logic                     done_q;
	logic [15:0]              rdata_q;
	logic                     strobe;  // pins active
	logic                     last_strobe;

	assign last_strobe = busy_q && (cnt_q == SRAM_CNT_BITS'(SRAM_ACCESS_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= last_strobe;
			if (!busy_q) begin
				if (mem_cmd_i.start) begin
					busy_q <= 1'b1;
					cnt_q  <= '0;
				end
			end else if (cnt_q == SRAM_CNT_BITS'(SRAM_ACCESS_CYCLES)) begin
				busy_q <= 1'b0; // done cycle over, ready again
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy_q && mem_cmd_i.start)
			cmd_q <= mem_cmd_i;
		if (last_strobe)
			rdata_q <= (cmd_q.mapped && !cmd_q.we) ? ram_data_i : 16'h0000;
	end

	//------------------------------------------------------------
	// pins
	//------------------------------------------------------------
	assign strobe = busy_q && cmd_q.mapped &&
		(cnt_q < SRAM_CNT_BITS'(SRAM_ACCESS_CYCLES));

	assign ram_addr_o = cmd_q.sram_addr;
	assign ram_data_o = cmd_q.wdata;
	assign _ram_we_o  = !(strobe && cmd_q.we);
	assign _ram_oe_o  = !(strobe && !cmd_q.we);
	assign _ram_bhe_o = !(strobe && cmd_q.be[1]);
	assign _ram_ble_o = !(strobe && cmd_q.be[0]);

	assign mem_rsp_o = '{done: done_q, rdata: rdata_q};

	a_we_oe_excl: assert property (@(posedge clk) disable iff (reset)
		!(!_ram_we_o && !_ram_oe_o));

endmodule

`default_nettype wire

/* source/memory_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_decoder (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            ovl_i,     // kickstart overlay
	input  wire minimig_bus_pkg::bus_req_t gnt_req_i,
	output minimig_bus_pkg::mem_cmd_t      mem_cmd_o
);
	import minimig_bus_pkg::*;
	import minimig_map_pkg::*;

	logic [4:0]                seg;    // 512k window
	logic [BANK_WORD_BITS-1:0] offset;
	bank_t                     bank;

	assign seg    = gnt_req_i.addr[22:18];
	assign offset = gnt_req_i.addr[BANK_WORD_BITS-1:0];

	always_comb begin
		mem_cmd_o.start  = gnt_req_i.active;
		mem_cmd_o.we     = gnt_req_i.we;
		mem_cmd_o.be     = gnt_req_i.be;
		mem_cmd_o.wdata  = gnt_req_i.wdata;
		mem_cmd_o.mapped = 1'b1;
		bank             = BANK_CHIP;
		case (seg)
			CHIP_BASE: begin
				// overlay: reads see rom, writes still hit chip
				if (ovl_i && !gnt_req_i.we)
					bank = BANK_KICK;
			end
			SLOW_BASE: bank = BANK_SLOW;
			KICK_BASE: begin
				bank         = BANK_KICK;
				mem_cmd_o.we = 1'b0; // rom is read only
			end
			default: begin
				mem_cmd_o.mapped = 1'b0; // nothing there
				mem_cmd_o.we     = 1'b0;
			end
		endcase
		mem_cmd_o.sram_addr = {bank, offset};
	end

	// bank 3 has no memory behind it
	a_bank_range: assert property (@(posedge clk) disable iff (reset)
		mem_cmd_o.start && mem_cmd_o.mapped |->
		mem_cmd_o.sram_addr[SRAM_ADDR_BITS-1 -: 2] != 2'd3);

endmodule

`default_nettype wire

/* source/chip_bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module chip_bus_arbiter (
	input  wire                            clk,
	input  wire                            reset,
	input  wire minimig_bus_pkg::bus_req_t cpu_req_i,
	input  wire minimig_bus_pkg::bus_req_t dma_req_i,
	output minimig_bus_pkg::bus_rsp_t      cpu_rsp_o,
	output minimig_bus_pkg::bus_rsp_t      dma_rsp_o,
	output minimig_bus_pkg::bus_req_t      gnt_req_o,
	input  wire minimig_bus_pkg::bus_rsp_t mem_rsp_i
);
	import minimig_bus_pkg::*;

	master_t  owner_q;
	bus_req_t gnt_q;    // latched request of the owner
	logic     cpu_own;

	//------------------------------------------------------------
	// grant, dma first like dbr
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			owner_q      <= MASTER_CPU;
			gnt_q.active <= 1'b0;
		end else if (gnt_q.active) begin
			if (mem_rsp_i.done)
				gnt_q.active <= 1'b0; // bus free next cycle
		end else if (dma_req_i.active) begin
			owner_q <= MASTER_DMA;
			gnt_q   <= dma_req_i;
		end else if (cpu_req_i.active) begin
			owner_q <= MASTER_CPU;
			gnt_q   <= cpu_req_i;
		end
	end

	assign gnt_req_o = gnt_q;
	assign cpu_own   = (owner_q == MASTER_CPU);

	// completion only to whoever holds the bus
	assign cpu_rsp_o = '{done: mem_rsp_i.done & cpu_own,
		rdata: cpu_own ? mem_rsp_i.rdata : 16'h0000};
	assign dma_rsp_o = '{done: mem_rsp_i.done & !cpu_own,
		rdata: cpu_own ? 16'h0000 : mem_rsp_i.rdata};

	a_one_done: assert property (@(posedge clk) disable iff (reset)
		!(cpu_rsp_o.done && dma_rsp_o.done));

endmodule

`default_nettype wire

/* source/bitplane_dma.sv */
`timescale 1ns/1ns
`default_nettype none

module bitplane_dma (
	input  wire                                        clk,
	input  wire                                        reset,
	input  wire                                        dma_start_i,
	input  wire [minimig_map_pkg::BANK_WORD_BITS-1:0]  dma_ptr_i,   // chip word pointer
	input  wire [7:0]                                  dma_len_i,   // words to fetch
	output logic [15:0]                                dma_data_o,
	output logic                                       dma_valid_o,
	output logic                                       dma_busy_o,
	output minimig_bus_pkg::bus_req_t                  req_o,
	input  wire minimig_bus_pkg::bus_rsp_t             rsp_i
);
	import minimig_bus_pkg::*;
	import minimig_map_pkg::*;

	logic [BANK_WORD_BITS-1:0] ptr_q;
	logic [7:0]                cnt_q;  // words still to fetch
	logic                      busy_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
		end else if (!busy_q) begin
			if (dma_start_i && dma_len_i != 8'd0)
				busy_q <= 1'b1;
		end else if (rsp_i.done && cnt_q == 8'd1) begin
			busy_q <= 1'b0; // last word in
		end
	end

	// pointer and count, start while busy is dropped
	always_ff @(posedge clk) begin
		if (!busy_q && dma_start_i) begin
			ptr_q <= dma_ptr_i;
			cnt_q <= dma_len_i;
		end else if (busy_q && rsp_i.done) begin
			ptr_q <= ptr_q + 1'b1;
			cnt_q <= cnt_q - 8'd1;
		end
	end

	// read only, full word, chip bank
	assign req_o = '{active: busy_q, addr: {CHIP_BASE, ptr_q}, we: 1'b0,
		be: 2'b11, wdata: 16'h0000};

	assign dma_valid_o = rsp_i.done;  // done only reaches the owner
	assign dma_data_o  = rsp_i.rdata;
	assign dma_busy_o  = busy_q;

	// a word may only show up while a run is active
	a_valid_in_run: assert property (@(posedge clk) disable iff (reset)
		dma_valid_o |-> dma_busy_o);

endmodule

`default_nettype wire

/* source/cpu_bus_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_bridge (
	input  wire                        clk,
	input  wire                        reset,
	input  wire [22:0]                 cpu_addr_i,  // a[23:1]
	input  wire [15:0]                 cpu_wdata_i,
	input  wire                        _cpu_as_i,
	input  wire                        _cpu_uds_i,
	input  wire                        _cpu_lds_i,
	input  wire                        cpu_r_w_i,
	output logic [15:0]                cpu_data_o,
	output logic                       _cpu_dtack_o,
	output minimig_bus_pkg::bus_req_t  req_o,
	input  wire minimig_bus_pkg::bus_rsp_t rsp_i
);
	import minimig_bus_pkg::*;

	bus_req_t    req_q;
	logic        as_q;     // _as one cycle back
	logic        dtack_q;  // active low
	logic        as_fall;
	logic [15:0] data_q;

	// new cycle only after _as was seen high
	assign as_fall = !_cpu_as_i && as_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			as_q         <= 1'b1;
			req_q.active <= 1'b0;
			dtack_q      <= 1'b1;
		end else begin
			as_q <= _cpu_as_i;
			if (as_fall && dtack_q && !req_q.active) begin
				req_q <= '{active: 1'b1, addr: cpu_addr_i, we: !cpu_r_w_i,
					be: {!_cpu_uds_i, !_cpu_lds_i}, wdata: cpu_wdata_i};
			end else if (req_q.active && rsp_i.done) begin
				req_q.active <= 1'b0;
				dtack_q      <= 1'b0; // ack the cycle after done
			end else if (!dtack_q && _cpu_as_i) begin
				dtack_q <= 1'b1;      // cpu ended its cycle
			end
		end
	end

	// read data held while dtack is low
	always_ff @(posedge clk) begin
		if (req_q.active && rsp_i.done)
			data_q <= rsp_i.rdata;
	end

	assign req_o        = req_q;
	assign cpu_data_o   = data_q;
	assign _cpu_dtack_o = dtack_q;

	// arbiter may sit on the request for a while, fields must not move
	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		req_q.active && $past(req_q.active) |->
		$stable({req_q.addr, req_q.we, req_q.be, req_q.wdata}));

endmodule

`default_nettype wire

/* source/minimig_bus_pkg.sv */
`default_nettype none

package minimig_bus_pkg;

	// one memory request, held by its master until done comes back
	typedef struct packed {
		logic        active; // request pending
		logic [22:0] addr;   // word address, cpu a[23:1]
		logic        we;     // write
		logic [1:0]  be;     // [1] upper byte, [0] lower byte
		logic [15:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic        done;   // single cycle, like dtack
		logic [15:0] rdata;  // valid with done
	} bus_rsp_t;

	// current owner of the chip bus
	typedef enum logic [0:0] {
		MASTER_CPU = 1'b0,
		MASTER_DMA = 1'b1
	} master_t;

	// decoded command between gary-style decoder and sram bridge
	typedef struct packed {
		logic                                       start;
		logic [minimig_map_pkg::SRAM_ADDR_BITS-1:0] sram_addr; // {bank, offset}
		logic                                       we;        // already 0 for kick
		logic [1:0]                                 be;
		logic [15:0]                                wdata;
		logic                                       mapped;    // 0 -> no strobes
	} mem_cmd_t;

endpackage

`default_nettype wire

/* source/minimig_map_pkg.sv */
`default_nettype none

package minimig_map_pkg;

	//------------------------------------------------------------
	// address map, 512k banks in word units
	//------------------------------------------------------------
	localparam int BANK_WORD_BITS = 18; // 256k words per bank
	localparam int SRAM_ADDR_BITS = 20; // bank number on top of offset

	typedef logic [1:0] bank_t;

	localparam bank_t BANK_CHIP = 2'd0;
	localparam bank_t BANK_SLOW = 2'd1;
	localparam bank_t BANK_KICK = 2'd2;

	// addr[22:18], i.e. byte address bits 23:19
	localparam logic [4:0] CHIP_BASE = 5'h00; // 0x000000
	localparam logic [4:0] SLOW_BASE = 5'h18; // 0xc00000
	localparam logic [4:0] KICK_BASE = 5'h1f; // 0xf80000

	//------------------------------------------------------------
	// sram pin cycle
	//------------------------------------------------------------
	localparam int SRAM_ACCESS_CYCLES = 2; // strobes low this long
	localparam int SRAM_CNT_BITS      = 2; // holds 0..SRAM_ACCESS_CYCLES

endpackage

`default_nettype wire
